//--- Bender.yml
package:
  name: du_debug_unit

sources:
  - du_pkg.sv
  - du_cmd_fsm.sv
  - du_prog_loader.sv
  - du_dump_engine.sv
  - du_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_du.sv

//--- du_cmd_fsm.sv
`timescale 1ns/1ps

module du_cmd_fsm (
    input  logic              i_clock,
    input  logic              i_reset,
    input  logic              i_rx_done,
    input  du_pkg::byte_t     i_rx_data,
    input  logic              i_hlt,
    input  logic              i_load_done,
    input  logic              i_dump_done,
    output logic              o_load_active,
    output logic              o_dump_go,
    output du_pkg::dump_src_t o_dump_src,
    output du_pkg::dp_ctrl_t  o_dp_ctrl,
    output logic              o_step
);
    import du_pkg::*;

    du_state_t state;
    du_state_t next_state;
    cmd_t      cmd;
    logic      step_seq;     // Set while the PC, DM, BR chain of a step runs
    logic      step_cmd;
    logic      enter_send;
    dump_src_t src_next;
    dp_ctrl_t  ctrl_next;

    assign cmd = cmd_t'(i_rx_data);

    // Halt wins over a step command arriving in the same cycle
    assign step_cmd = (state == STEP_BY_STEP) && !i_hlt && i_rx_done && (cmd == CMD_STEP);

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (i_rx_done) begin
                    case (cmd)
                        CMD_WRITE_IM: next_state = WRITE_IM;
                        CMD_SEND_PC:  next_state = SEND_PC;
                        CMD_SEND_MEM: next_state = SEND_MEM;
                        CMD_SEND_BR:  next_state = SEND_BR;
                        default:      next_state = IDLE;   // Unknown byte ignored
                    endcase
                end
            end
            WRITE_IM: begin
                if (i_load_done)
                    next_state = READY;
            end
            READY: begin
                if (i_rx_done) begin
                    case (cmd)
                        CMD_START:        next_state = START;
                        CMD_STEP_BY_STEP: next_state = STEP_BY_STEP;
                        default:          next_state = READY;
                    endcase
                end
            end
            START: begin
                if (i_hlt)
                    next_state = IDLE;
            end
            STEP_BY_STEP: begin
                if (i_hlt) begin
                    next_state = IDLE;
                end else if (i_rx_done) begin
                    case (cmd)
                        CMD_STEP:     next_state = SEND_PC;
                        CMD_CONTINUE: next_state = START;
                        default:      next_state = STEP_BY_STEP;
                    endcase
                end
            end
            SEND_PC: begin
                if (i_dump_done)
                    next_state = step_seq ? SEND_MEM : IDLE;
            end
            SEND_MEM: begin
                if (i_dump_done)
                    next_state = step_seq ? SEND_BR : IDLE;
            end
            SEND_BR: begin
                if (i_dump_done)
                    next_state = step_seq ? STEP_BY_STEP : IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    // Source for the dump about to start
    always_comb begin
        case (next_state)
            SEND_MEM: src_next = SRC_DM;
            SEND_BR:  src_next = SRC_BR;
            default:  src_next = SRC_PC;
        endcase
    end

    assign enter_send = (next_state != state) &&
                        (next_state inside {SEND_PC, SEND_MEM, SEND_BR});

    // Run controls follow the current state
    always_comb begin
        ctrl_next = '0;
        if (state == START || state == STEP_BY_STEP) begin
            ctrl_next.im_enable = 1'b1;
            ctrl_next.rb_enable = 1'b1;
            ctrl_next.dm_enable = 1'b1;
            ctrl_next.cu_enable = 1'b1;
            ctrl_next.pc_enable = 1'b1;
            ctrl_next.step_flag = (state == STEP_BY_STEP);
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state      <= IDLE;
            step_seq   <= 1'b0;
            o_dump_go  <= 1'b0;
            o_dump_src <= SRC_PC;
            o_dp_ctrl  <= '0;
            o_step     <= 1'b0;
        end else begin
            state     <= next_state;
            o_dump_go <= enter_send;   // One pulse on entry to each SEND state
            o_dp_ctrl <= ctrl_next;
            o_step    <= step_cmd;
            if (enter_send)
                o_dump_src <= src_next;
            if (step_cmd)
                step_seq <= 1'b1;
            else if (next_state == IDLE || next_state == STEP_BY_STEP)
                step_seq <= 1'b0;
        end
    end

    assign o_load_active = (state == WRITE_IM);

endmodule

//--- du_dump_engine.sv
`timescale 1ns/1ps

module du_dump_engine #(
    parameter int RB_DEPTH = du_pkg::DEF_RB_DEPTH,
    parameter int DM_DEPTH = du_pkg::DEF_DM_DEPTH
) (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_dump_go,
    input  du_pkg::dump_src_t           i_dump_src,
    input  logic                        i_tx_done,
    input  du_pkg::word_t               i_pc_value,
    input  du_pkg::word_t               i_br_data,
    input  du_pkg::word_t               i_dm_data,
    output logic                        o_tx_start,
    output du_pkg::byte_t               o_tx_data,
    output logic [$clog2(RB_DEPTH)-1:0] o_rb_addr,
    output logic [$clog2(DM_DEPTH)-1:0] o_dm_addr,
    output logic                        o_rb_read_enable,
    output logic                        o_dm_read_enable,
    output logic                        o_dump_done
);
    import du_pkg::*;

    localparam int RB_AW = $clog2(RB_DEPTH);
    localparam int DM_AW = $clog2(DM_DEPTH);
    localparam int CNT_W = (RB_AW > DM_AW) ? RB_AW : DM_AW;

    dump_src_t        src_q;
    byte_sel_t        byte_sel;   // 0 is the most significant byte
    logic [CNT_W-1:0] word_cnt;
    logic [CNT_W-1:0] word_last;
    logic             last_word;
    word_t            cur_word;

    // Word limit from the depth of the latched source
    always_comb begin
        case (src_q)
            SRC_DM:  word_last = CNT_W'(DM_DEPTH - 1);
            SRC_BR:  word_last = CNT_W'(RB_DEPTH - 1);
            default: word_last = '0;   // PC is a single word
        endcase
    end

    assign last_word = (word_cnt == word_last);

    always_comb begin
        case (src_q)
            SRC_DM:  cur_word = i_dm_data;
            SRC_BR:  cur_word = i_br_data;
            default: cur_word = i_pc_value;
        endcase
    end

    // Byte on the transmit bus, held until the counters move
    always_comb begin
        case (byte_sel)
            2'd0:    o_tx_data = cur_word[31:24];
            2'd1:    o_tx_data = cur_word[23:16];
            2'd2:    o_tx_data = cur_word[15:8];
            default: o_tx_data = cur_word[7:0];
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_tx_start  <= 1'b0;
            o_dump_done <= 1'b0;
            src_q       <= SRC_PC;
            byte_sel    <= '0;
            word_cnt    <= '0;
        end else begin
            o_dump_done <= 1'b0;
            if (!o_tx_start) begin
                if (i_dump_go) begin   // A new request is only taken when idle
                    o_tx_start <= 1'b1;
                    src_q      <= i_dump_src;
                    byte_sel   <= '0;
                    word_cnt   <= '0;
                end
            end else if (i_tx_done) begin
                byte_sel <= byte_sel + 1'b1;
                if (byte_sel == 2'd3) begin
                    if (last_word) begin
                        o_tx_start  <= 1'b0;
                        o_dump_done <= 1'b1;
                        word_cnt    <= '0;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // Asynchronous read ports follow the word counter
    assign o_rb_addr        = word_cnt[RB_AW-1:0];
    assign o_dm_addr        = word_cnt[DM_AW-1:0];
    assign o_rb_read_enable = o_tx_start && (src_q == SRC_BR);
    assign o_dm_read_enable = o_tx_start && (src_q == SRC_DM);

endmodule

//--- du_pkg.sv
package du_pkg;

    // Widths that carry a meaning
    typedef logic [7:0]  byte_t;      // One UART byte
    typedef logic [31:0] word_t;      // PC, register or memory word
    typedef logic [1:0]  byte_sel_t;  // Byte index within a word

    // Command codes received over the UART link
    typedef enum byte_t {
        CMD_WRITE_IM     = 8'd1,
        CMD_START        = 8'd2,
        CMD_STEP_BY_STEP = 8'd3,
        CMD_SEND_BR      = 8'd4,
        CMD_SEND_MEM     = 8'd5,
        CMD_SEND_PC      = 8'd6,
        CMD_STEP         = 8'd7,
        CMD_CONTINUE     = 8'd8
    } cmd_t;

    // Command FSM states
    typedef enum logic [3:0] {
        IDLE,
        WRITE_IM,
        READY,
        START,
        STEP_BY_STEP,
        SEND_PC,
        SEND_MEM,
        SEND_BR
    } du_state_t;

    // Which word source a dump reads from
    typedef enum logic [1:0] {
        SRC_PC,
        SRC_DM,
        SRC_BR
    } dump_src_t;

    // Datapath run controls
    typedef struct packed {
        logic im_enable;
        logic rb_enable;
        logic dm_enable;
        logic cu_enable;
        logic pc_enable;
        logic step_flag;   // Datapath advances only on step pulses
    } dp_ctrl_t;

    // Default memory depths
    localparam int DEF_IM_DEPTH = 256;
    localparam int DEF_RB_DEPTH = 32;
    localparam int DEF_DM_DEPTH = 32;

endpackage

//--- du_prog_loader.sv
`timescale 1ns/1ps

module du_prog_loader #(
    parameter int IM_DEPTH = du_pkg::DEF_IM_DEPTH
) (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_load_active,
    input  logic                        i_rx_done,
    input  du_pkg::byte_t               i_rx_data,
    output logic                        o_im_write_enable,
    output logic [$clog2(IM_DEPTH)-1:0] o_im_addr,
    output du_pkg::byte_t               o_im_data,
    output logic                        o_load_done
);
    localparam int IM_AW = $clog2(IM_DEPTH);

    logic [IM_AW-1:0] byte_cnt;   // Address of the next program byte
    logic             last_byte;
    logic             take;

    assign take      = i_load_active && i_rx_done;
    assign last_byte = (byte_cnt == IM_AW'(IM_DEPTH - 1));

    // Control state
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            byte_cnt          <= '0;
            o_im_write_enable <= 1'b0;
            o_load_done       <= 1'b0;
        end else begin
            o_im_write_enable <= take;
            o_load_done       <= take && last_byte;   // Comes with the final write
            if (take)
                byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
        end
    end

    // Address and data for the write strobe
    always_ff @(posedge i_clock) begin
        if (take) begin
            o_im_addr <= byte_cnt;
            o_im_data <= i_rx_data;
        end
    end

endmodule

//--- du_top.sv
`timescale 1ns/1ps

module du_top #(
    parameter int IM_DEPTH = du_pkg::DEF_IM_DEPTH,
    parameter int RB_DEPTH = du_pkg::DEF_RB_DEPTH,
    parameter int DM_DEPTH = du_pkg::DEF_DM_DEPTH
) (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_rx_done,    // UART receiver strobe
    input  du_pkg::byte_t               i_rx_data,
    input  logic                        i_tx_done,    // UART transmitter byte sent
    output logic                        o_tx_start,
    output du_pkg::byte_t               o_tx_data,
    input  logic                        i_hlt,
    input  du_pkg::word_t               i_pc_value,
    input  du_pkg::word_t               i_br_data,
    input  du_pkg::word_t               i_dm_data,
    output logic [$clog2(RB_DEPTH)-1:0] o_rb_addr,
    output logic [$clog2(DM_DEPTH)-1:0] o_dm_addr,
    output logic                        o_rb_read_enable,
    output logic                        o_dm_read_enable,
    output logic                        o_im_write_enable,
    output logic [$clog2(IM_DEPTH)-1:0] o_im_addr,
    output du_pkg::byte_t               o_im_data,
    output du_pkg::dp_ctrl_t            o_dp_ctrl,
    output logic                        o_step
);
    import du_pkg::*;

    logic      load_active;
    logic      load_done;
    logic      dump_go;
    dump_src_t dump_src;
    logic      dump_done;

    du_cmd_fsm u_cmd_fsm (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_rx_done     (i_rx_done),
        .i_rx_data     (i_rx_data),
        .i_hlt         (i_hlt),
        .i_load_done   (load_done),
        .i_dump_done   (dump_done),
        .o_load_active (load_active),
        .o_dump_go     (dump_go),
        .o_dump_src    (dump_src),
        .o_dp_ctrl     (o_dp_ctrl),
        .o_step        (o_step)
    );

    du_prog_loader #(
        .IM_DEPTH (IM_DEPTH)
    ) u_prog_loader (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_load_active     (load_active),
        .i_rx_done         (i_rx_done),
        .i_rx_data         (i_rx_data),
        .o_im_write_enable (o_im_write_enable),
        .o_im_addr         (o_im_addr),
        .o_im_data         (o_im_data),
        .o_load_done       (load_done)
    );

    du_dump_engine #(
        .RB_DEPTH (RB_DEPTH),
        .DM_DEPTH (DM_DEPTH)
    ) u_dump_engine (
        .i_clock          (i_clock),
        .i_reset          (i_reset),
        .i_dump_go        (dump_go),
        .i_dump_src       (dump_src),
        .i_tx_done        (i_tx_done),
        .i_pc_value       (i_pc_value),
        .i_br_data        (i_br_data),
        .i_dm_data        (i_dm_data),
        .o_tx_start       (o_tx_start),
        .o_tx_data        (o_tx_data),
        .o_rb_addr        (o_rb_addr),
        .o_dm_addr        (o_dm_addr),
        .o_rb_read_enable (o_rb_read_enable),
        .o_dm_read_enable (o_dm_read_enable),
        .o_dump_done      (dump_done)
    );

endmodule

//--- sim.f
+incdir+.
du_pkg.sv
du_cmd_fsm.sv
du_prog_loader.sv
du_dump_engine.sv
du_top.sv
tb_du.sv

//--- tb_du_checks.svh
task automatic step_clk();
    @(posedge i_clock);
    #1;   // Drive and sample just after the edge
endtask

task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped at the first error");
endtask

task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (act !== exp)
        stop_with_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
endtask

task automatic check_ctrl(input string name, input dp_ctrl_t exp, input dp_ctrl_t act);
    if (act !== exp)
        stop_with_error($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
        stop_with_error($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
endtask

task automatic wait_im_writes(input int target);
    int cycles;
    cycles = 0;
    while (im_write_count < target) begin
        if (cycles == TIMEOUT_CYCLES) begin
            stop_with_error($sformatf("Timeout in %s: only %0d of %0d program writes came",
                                      test_name, im_write_count, target));
        end else begin
            step_clk();
            cycles++;
        end
    end
endtask

// Expected bytes all seen and transmit start back low
task automatic wait_stream_done();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 || o_tx_start !== 1'b0) begin
        if (cycles == TIMEOUT_CYCLES) begin
            stop_with_error($sformatf("Timeout in %s: dump stream never finished, %0d bytes missing",
                                      test_name, exp_q.size()));
        end else begin
            step_clk();
            cycles++;
        end
    end
endtask

//--- tb_du.sv
`timescale 1ns/1ps

module tb_du;
    import du_pkg::*;

    localparam int IM_DEPTH       = 16;
    localparam int RB_DEPTH       = 8;
    localparam int DM_DEPTH       = 8;
    localparam int TIMEOUT_CYCLES = 4000;

    logic                        i_clock;
    logic                        i_reset;
    logic                        i_rx_done;
    byte_t                       i_rx_data;
    logic                        i_tx_done;
    logic                        o_tx_start;
    byte_t                       o_tx_data;
    logic                        i_hlt;
    word_t                       i_pc_value;
    word_t                       i_br_data;
    word_t                       i_dm_data;
    logic [$clog2(RB_DEPTH)-1:0] o_rb_addr;
    logic [$clog2(DM_DEPTH)-1:0] o_dm_addr;
    logic                        o_rb_read_enable;
    logic                        o_dm_read_enable;
    logic                        o_im_write_enable;
    logic [$clog2(IM_DEPTH)-1:0] o_im_addr;
    byte_t                       o_im_data;
    dp_ctrl_t                    o_dp_ctrl;
    logic                        o_step;

    word_t      br_mem [RB_DEPTH];
    word_t      dm_mem [DM_DEPTH];
    byte_t      prog [2*IM_DEPTH];   // Two program loads
    byte_t      exp_q [$];
    dump_src_t  exp_src_q [$];       // Source of each expected byte
    byte_t      cap_q [$];
    logic [1:0] cap_en_q [$];        // Read enables seen with each byte
    int         im_write_count;
    int         step_count;
    int         byte_count;
    string      test_name;

    `include "tb_du_checks.svh"

    du_top #(
        .IM_DEPTH (IM_DEPTH),
        .RB_DEPTH (RB_DEPTH),
        .DM_DEPTH (DM_DEPTH)
    ) u_dut (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_rx_done         (i_rx_done),
        .i_rx_data         (i_rx_data),
        .i_tx_done         (i_tx_done),
        .o_tx_start        (o_tx_start),
        .o_tx_data         (o_tx_data),
        .i_hlt             (i_hlt),
        .i_pc_value        (i_pc_value),
        .i_br_data         (i_br_data),
        .i_dm_data         (i_dm_data),
        .o_rb_addr         (o_rb_addr),
        .o_dm_addr         (o_dm_addr),
        .o_rb_read_enable  (o_rb_read_enable),
        .o_dm_read_enable  (o_dm_read_enable),
        .o_im_write_enable (o_im_write_enable),
        .o_im_addr         (o_im_addr),
        .o_im_data         (o_im_data),
        .o_dp_ctrl         (o_dp_ctrl),
        .o_step            (o_step)
    );

    always #4 i_clock = ~i_clock;   // 8 ns period

    // Asynchronous read ports
    assign i_br_data = br_mem[o_rb_addr];
    assign i_dm_data = dm_mem[o_dm_addr];

    // Word k of the source, most significant byte first
    function automatic byte_t expected_byte(input dump_src_t src, input int idx);
        word_t w;
        case (src)
            SRC_DM:  w = dm_mem[idx / 4];
            SRC_BR:  w = br_mem[idx / 4];
            default: w = i_pc_value;
        endcase
        return w[31 - 8*(idx % 4) -: 8];
    endfunction

    function automatic dp_ctrl_t expected_ctrl(input logic run, input logic step);
        return {run, run, run, run, run, run && step};
    endfunction

    task automatic queue_words(input dump_src_t src, input int words);
        for (int i = 0; i < 4*words; i++) begin
            exp_q.push_back(expected_byte(src, i));
            exp_src_q.push_back(src);
        end
    endtask

    task automatic send_cmd(input byte_t value);
        i_rx_data = value;
        i_rx_done = 1'b1;
        step_clk();
        i_rx_done = 1'b0;
        step_clk();
    endtask

    task automatic load_program(input string name);
        int base;
        base      = im_write_count;
        test_name = name;
        send_cmd(CMD_WRITE_IM);
        for (int i = 0; i < IM_DEPTH; i++)
            send_cmd(prog[base + i]);
        wait_im_writes(base + IM_DEPTH);
    endtask

    task automatic halt_datapath(input string name);
        i_hlt = 1'b1;
        step_clk();
        i_hlt = 1'b0;
        step_clk();
        check_ctrl({name, " dp_ctrl"}, '0, o_dp_ctrl);
    endtask

    task automatic run_dump(input string name, input cmd_t cmd, input dump_src_t src,
                            input int words);
        test_name = name;
        queue_words(src, words);
        send_cmd(cmd);
        wait_stream_done();
        check_bit({name, " rb_read_enable idle"}, 1'b0, o_rb_read_enable);
        check_bit({name, " dm_read_enable idle"}, 1'b0, o_dm_read_enable);
        repeat (2) step_clk();   // FSM back in IDLE
    endtask

    // UART transmitter with a random byte time
    initial begin : tx_model
        int gap;
        i_tx_done = 1'b0;
        forever begin
            step_clk();
            if (o_tx_start === 1'b1) begin
                gap = 2 + ($urandom % 5);
                repeat (gap - 1) step_clk();
                cap_q.push_back(o_tx_data);
                cap_en_q.push_back({o_rb_read_enable, o_dm_read_enable});
                i_tx_done = 1'b1;
                step_clk();
                i_tx_done = 1'b0;
            end
        end
    end

    always @(posedge i_clock) begin : compare_bytes
        byte_t      got;
        logic [1:0] got_en;   // Register bank then data memory
        dump_src_t  src;
        if (cap_q.size() != 0) begin
            got    = cap_q.pop_front();
            got_en = cap_en_q.pop_front();
            if (exp_q.size() == 0) begin
                stop_with_error($sformatf("In %s the transmitter got an extra byte", test_name));
            end else begin
                src = exp_src_q.pop_front();
                check_byte($sformatf("%s byte %0d", test_name, byte_count), exp_q.pop_front(), got);
                check_bit($sformatf("%s rb_read_enable %0d", test_name, byte_count),
                          src == SRC_BR, got_en[1]);
                check_bit($sformatf("%s dm_read_enable %0d", test_name, byte_count),
                          src == SRC_DM, got_en[0]);
            end
            byte_count++;
        end
    end

    // Program writes and step pulses
    always @(posedge i_clock) begin
        if (!i_reset && o_im_write_enable) begin
            check_byte({test_name, " im_addr"}, byte_t'(im_write_count % IM_DEPTH),
                       byte_t'(o_im_addr));
            check_byte({test_name, " im_data"}, prog[im_write_count], o_im_data);
            im_write_count++;
        end
        if (!i_reset && o_step)
            step_count++;
    end

    initial begin
        void'($urandom(30008));
        i_clock        = 1'b0;
        i_reset        = 1'b1;
        i_rx_done      = 1'b0;
        i_rx_data      = '0;
        i_hlt          = 1'b0;
        i_pc_value     = $urandom();
        im_write_count = 0;
        step_count     = 0;
        byte_count     = 0;
        test_name      = "reset";
        foreach (br_mem[i])
            br_mem[i] = $urandom();
        foreach (dm_mem[i])
            dm_mem[i] = $urandom();
        foreach (prog[i])
            prog[i] = byte_t'($urandom());
        repeat (4) @(posedge i_clock);
        #1;
        i_reset = 1'b0;
        step_clk();
        check_ctrl("reset dp_ctrl", '0, o_dp_ctrl);
        check_bit("reset step", 1'b0, o_step);
        check_bit("reset tx_start", 1'b0, o_tx_start);
        check_bit("reset im_write_enable", 1'b0, o_im_write_enable);
        check_bit("reset rb_read_enable", 1'b0, o_rb_read_enable);
        check_bit("reset dm_read_enable", 1'b0, o_dm_read_enable);

        load_program("load");
        repeat (3) step_clk();
        check_byte("load write count", byte_t'(IM_DEPTH), byte_t'(im_write_count));
        check_ctrl("load ready", '0, o_dp_ctrl);

        test_name = "start";
        send_cmd(CMD_START);
        check_ctrl("start dp_ctrl", expected_ctrl(1'b1, 1'b0), o_dp_ctrl);
        halt_datapath("start halt");

        run_dump("send pc", CMD_SEND_PC, SRC_PC, 1);
        run_dump("send br", CMD_SEND_BR, SRC_BR, RB_DEPTH);
        run_dump("send mem", CMD_SEND_MEM, SRC_DM, DM_DEPTH);

        // Step mode dumps PC, data memory, then register bank
        load_program("reload");
        send_cmd(CMD_STEP_BY_STEP);
        check_ctrl("step mode dp_ctrl", expected_ctrl(1'b1, 1'b1), o_dp_ctrl);
        test_name = "step";
        queue_words(SRC_PC, 1);
        queue_words(SRC_DM, DM_DEPTH);
        queue_words(SRC_BR, RB_DEPTH);
        send_cmd(CMD_STEP);
        wait_stream_done();
        repeat (2) step_clk();
        check_byte("step pulses", 8'd1, byte_t'(step_count));
        check_ctrl("step return dp_ctrl", expected_ctrl(1'b1, 1'b1), o_dp_ctrl);

        test_name = "continue";
        send_cmd(CMD_CONTINUE);
        check_ctrl("continue dp_ctrl", expected_ctrl(1'b1, 1'b0), o_dp_ctrl);
        halt_datapath("continue halt");

        test_name = "unknown";
        send_cmd(8'hA5);
        repeat (2) step_clk();
        check_ctrl("unknown dp_ctrl", '0, o_dp_ctrl);
        check_bit("unknown tx_start", 1'b0, o_tx_start);
        check_byte("unknown write count", byte_t'(2*IM_DEPTH), byte_t'(im_write_count));
        run_dump("pc after unknown", CMD_SEND_PC, SRC_PC, 1);

        check_byte("final step pulses", 8'd1, byte_t'(step_count));
        $display(">>> PASS");
        $finish;
    end

endmodule
